// ==== src/noc_alloc_pkg.sv ====
`default_nettype none

package noc_alloc_pkg;

        // Five ports of a mesh router.
        localparam int unsigned NUM_PORTS = 5;

        // Next-hop direction, also used as the input index.
        typedef enum logic [2:0] {
                PORT_N = 3'd0,
                PORT_S = 3'd1,
                PORT_W = 3'd2,
                PORT_E = 3'd3,
                PORT_L = 3'd4
        } port_dir_e;

        typedef struct packed {
                logic      valid;
                port_dir_e next_hop;
        } port_req_t;

        typedef struct packed {
                logic      valid;
                port_dir_e src;
        } xbar_sel_t;

        typedef struct packed {
                logic        psel;
                logic        penable;
                logic        pwrite;
                logic [7:0]  paddr;
                logic [31:0] pwdata;
        } apb_req_t;

        typedef struct packed {
                logic [31:0] prdata;
                logic        pready;
                logic        pslverr;
        } apb_rsp_t;

        // Register map.
        typedef enum logic [7:0] {
                REG_PORT_EN   = 8'h00,
                REG_GNT_CNT_N = 8'h04,
                REG_GNT_CNT_S = 8'h08,
                REG_GNT_CNT_W = 8'h0C,
                REG_GNT_CNT_E = 8'h10,
                REG_GNT_CNT_L = 8'h14,
                REG_CNT_CLR   = 8'h18
        } reg_addr_e;

endpackage

`default_nettype wire

// ==== src/route_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_decoder (
        input  noc_alloc_pkg::port_req_t [noc_alloc_pkg::NUM_PORTS-1:0] req_i,
        input  logic [noc_alloc_pkg::NUM_PORTS-1:0]                     out_ready_i,
        input  logic [noc_alloc_pkg::NUM_PORTS-1:0]                     port_en_i,
        output logic [noc_alloc_pkg::NUM_PORTS-1:0][noc_alloc_pkg::NUM_PORTS-1:0] req_vec_o
);

        import noc_alloc_pkg::*;

        logic [NUM_PORTS-1:0] in_ok;
        logic [NUM_PORTS-1:0] out_ok;

        // An input may request only while valid and enabled.
        always_comb begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                        in_ok[i] = req_i[i].valid && port_en_i[i];
                end
        end

        // An output takes requests only while enabled and ready downstream.
        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        out_ok[o] = port_en_i[o] && out_ready_i[o];
                end
        end

        // Request matrix, indexed by output then input.
        always_comb begin
                req_vec_o = '0;
                for (int o = 0; o < NUM_PORTS; o++) begin
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                // No U-turn back into the same port.
                                if (o != i) begin
                                        req_vec_o[o][i] = in_ok[i] && out_ok[o] &&
                                                (req_i[i].next_hop == port_dir_e'(o));
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// ==== src/output_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_rr_arbiter (
        input  logic                                clk,
        input  logic                                arst_n_i,
        input  logic [noc_alloc_pkg::NUM_PORTS-1:0] req_i,
        output logic [noc_alloc_pkg::NUM_PORTS-1:0] gnt_o
);

        import noc_alloc_pkg::*;

        // Input that holds the highest priority this cycle.
        port_dir_e ptr_q;
        logic      grant_vld;
        port_dir_e win_dir;

        // Cyclic search starting at the pointer.
        always_comb begin
                int unsigned idx;
                gnt_o     = '0;
                grant_vld = 1'b0;
                win_dir   = PORT_N;
                for (int unsigned off = 0; off < NUM_PORTS; off++) begin
                        idx = ptr_q + off;
                        if (idx >= NUM_PORTS) begin
                                idx = idx - NUM_PORTS;
                        end
                        if (!grant_vld && req_i[idx]) begin
                                grant_vld  = 1'b1;
                                win_dir    = port_dir_e'(idx);
                                gnt_o[idx] = 1'b1;
                        end
                end
        end

        // Move past the winner; hold when nothing is granted.
        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        ptr_q <= PORT_N;
                end else if (grant_vld) begin
                        if (win_dir == PORT_L) begin
                                ptr_q <= PORT_N;
                        end else begin
                                ptr_q <= port_dir_e'(win_dir + 3'd1);
                        end
                end
        end

endmodule

`default_nettype wire

// ==== src/grant_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module grant_collector #(
        parameter int unsigned CNT_WIDTH = 16
) (
        input  logic                                                       clk,
        input  logic                                                       arst_n_i,
        input  logic [noc_alloc_pkg::NUM_PORTS-1:0][noc_alloc_pkg::NUM_PORTS-1:0] gnt_i,
        input  logic                                                       cnt_clr_i,
        output noc_alloc_pkg::xbar_sel_t [noc_alloc_pkg::NUM_PORTS-1:0]   xbar_sel_o,
        output logic [noc_alloc_pkg::NUM_PORTS-1:0]                       in_ack_o,
        output logic [noc_alloc_pkg::NUM_PORTS-1:0][CNT_WIDTH-1:0]        gnt_cnt_o
);

        import noc_alloc_pkg::*;

        xbar_sel_t [NUM_PORTS-1:0] sel_d;
        logic [NUM_PORTS-1:0]      ack_d;

        // One-hot grant to source direction, per output.
        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        sel_d[o].valid = |gnt_i[o];
                        sel_d[o].src   = PORT_N;
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                if (gnt_i[o][i]) begin
                                        sel_d[o].src = port_dir_e'(i);
                                end
                        end
                end
        end

        // An input is acknowledged if any output granted it.
        always_comb begin
                ack_d = '0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                        for (int o = 0; o < NUM_PORTS; o++) begin
                                ack_d[i] = ack_d[i] | gnt_i[o][i];
                        end
                end
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        xbar_sel_o <= '0;
                        in_ack_o   <= '0;
                end else begin
                        xbar_sel_o <= sel_d;
                        in_ack_o   <= ack_d;
                end
        end

        // Saturating grant counters; clear wins over a grant.
        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        gnt_cnt_o <= '0;
                end else if (cnt_clr_i) begin
                        gnt_cnt_o <= '0;
                end else begin
                        for (int o = 0; o < NUM_PORTS; o++) begin
                                if (sel_d[o].valid && (gnt_cnt_o[o] != '1)) begin
                                        gnt_cnt_o[o] <= gnt_cnt_o[o] + 1'b1;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// ==== src/alloc_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_apb_regs #(
        parameter int unsigned CNT_WIDTH = 16
) (
        input  logic                                                clk,
        input  logic                                                arst_n_i,
        input  noc_alloc_pkg::apb_req_t                             apb_req_i,
        output noc_alloc_pkg::apb_rsp_t                             apb_rsp_o,
        input  logic [noc_alloc_pkg::NUM_PORTS-1:0][CNT_WIDTH-1:0] gnt_cnt_i,
        output logic [noc_alloc_pkg::NUM_PORTS-1:0]                port_en_o,
        output logic                                                cnt_clr_o
);

        import noc_alloc_pkg::*;

        logic        access;
        logic        addr_ok;
        logic [31:0] rd_data;
        reg_addr_e   addr;

        assign access = apb_req_i.psel && apb_req_i.penable;
        assign addr   = reg_addr_e'(apb_req_i.paddr);

        // Address decode and read mux.
        always_comb begin
                addr_ok = 1'b1;
                rd_data = '0;
                case (addr)
                        REG_PORT_EN:   rd_data = 32'(port_en_o);
                        REG_GNT_CNT_N: rd_data = 32'(gnt_cnt_i[PORT_N]);
                        REG_GNT_CNT_S: rd_data = 32'(gnt_cnt_i[PORT_S]);
                        REG_GNT_CNT_W: rd_data = 32'(gnt_cnt_i[PORT_W]);
                        REG_GNT_CNT_E: rd_data = 32'(gnt_cnt_i[PORT_E]);
                        REG_GNT_CNT_L: rd_data = 32'(gnt_cnt_i[PORT_L]);
                        REG_CNT_CLR:   rd_data = '0;
                        default:       addr_ok = 1'b0;
                endcase
        end

        // No wait states; read data only in a read access phase.
        always_comb begin
                apb_rsp_o         = '0;
                apb_rsp_o.pready  = access;
                apb_rsp_o.pslverr = access && !addr_ok;
                if (access && !apb_req_i.pwrite && addr_ok) begin
                        apb_rsp_o.prdata = rd_data;
                end
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        port_en_o <= '1;
                end else if (access && apb_req_i.pwrite && (addr == REG_PORT_EN)) begin
                        port_en_o <= apb_req_i.pwdata[NUM_PORTS-1:0];
                end
        end

        // Clear pulse lasts one cycle, whatever value is written.
        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        cnt_clr_o <= 1'b0;
                end else begin
                        cnt_clr_o <= access && apb_req_i.pwrite && (addr == REG_CNT_CLR);
                end
        end

endmodule

`default_nettype wire

// ==== src/switch_allocator_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_allocator_top #(
        parameter int unsigned CNT_WIDTH = 16
) (
        input  logic                                                     clk,
        input  logic                                                     arst_n_i,
        input  noc_alloc_pkg::port_req_t [noc_alloc_pkg::NUM_PORTS-1:0] req_i,
        input  logic [noc_alloc_pkg::NUM_PORTS-1:0]                     out_ready_i,
        input  noc_alloc_pkg::apb_req_t                                  apb_req_i,
        output noc_alloc_pkg::xbar_sel_t [noc_alloc_pkg::NUM_PORTS-1:0] xbar_sel_o,
        output logic [noc_alloc_pkg::NUM_PORTS-1:0]                     in_ack_o,
        output noc_alloc_pkg::apb_rsp_t                                  apb_rsp_o
);

        import noc_alloc_pkg::*;

        logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req_vec;
        logic [NUM_PORTS-1:0][NUM_PORTS-1:0] gnt;
        logic [NUM_PORTS-1:0][CNT_WIDTH-1:0] gnt_cnt;
        logic [NUM_PORTS-1:0]                port_en;
        logic                                cnt_clr;

        route_decoder u_decoder (
                .req_i       (req_i),
                .out_ready_i (out_ready_i),
                .port_en_i   (port_en),
                .req_vec_o   (req_vec)
        );

        // One arbiter per output port.
        for (genvar k = 0; k < NUM_PORTS; k++) begin : g_arb
                output_rr_arbiter u_arb (
                        .clk      (clk),
                        .arst_n_i (arst_n_i),
                        .req_i    (req_vec[k]),
                        .gnt_o    (gnt[k])
                );
        end

        grant_collector #(.CNT_WIDTH(CNT_WIDTH)) u_collector (
                .clk        (clk),
                .arst_n_i   (arst_n_i),
                .gnt_i      (gnt),
                .cnt_clr_i  (cnt_clr),
                .xbar_sel_o (xbar_sel_o),
                .in_ack_o   (in_ack_o),
                .gnt_cnt_o  (gnt_cnt)
        );

        alloc_apb_regs #(.CNT_WIDTH(CNT_WIDTH)) u_regs (
                .clk       (clk),
                .arst_n_i  (arst_n_i),
                .apb_req_i (apb_req_i),
                .apb_rsp_o (apb_rsp_o),
                .gnt_cnt_i (gnt_cnt),
                .port_en_o (port_en),
                .cnt_clr_o (cnt_clr)
        );

endmodule

`default_nettype wire

// ==== verification/switch_allocator_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_allocator_assert (
        input  logic                                                     clk,
        input  logic                                                     arst_n_i,
        input  noc_alloc_pkg::xbar_sel_t [noc_alloc_pkg::NUM_PORTS-1:0] xbar_sel_i,
        input  logic [noc_alloc_pkg::NUM_PORTS-1:0]                     out_ready_i,
        input  noc_alloc_pkg::apb_req_t                                  apb_req_i,
        input  noc_alloc_pkg::apb_rsp_t                                  apb_rsp_i
);

        import noc_alloc_pkg::*;

        // Failures so far, watched by the testbench.
        int err_cnt = 0;

        for (genvar k = 0; k < NUM_PORTS; k++) begin : g_out
                a_legal_src: assert property (@(posedge clk) disable iff (!arst_n_i)
                        xbar_sel_i[k].valid |-> (xbar_sel_i[k].src <= PORT_L))
                else begin
                        err_cnt++;
                        $error("output %0d selects an illegal source", k);
                end

                a_no_uturn: assert property (@(posedge clk) disable iff (!arst_n_i)
                        xbar_sel_i[k].valid |-> (xbar_sel_i[k].src != port_dir_e'(k)))
                else begin
                        err_cnt++;
                        $error("output %0d granted to its own input", k);
                end

                // A grant needs the output ready on the edge that made it.
                a_ready_before: assert property (@(posedge clk) disable iff (!arst_n_i)
                        xbar_sel_i[k].valid |-> $past(out_ready_i[k]))
                else begin
                        err_cnt++;
                        $error("output %0d granted while not ready", k);
                end
        end

        a_pready: assert property (@(posedge clk) disable iff (!arst_n_i)
                (apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_i.pready)
        else begin
                err_cnt++;
                $error("APB access phase without pready");
        end

endmodule

bind switch_allocator_top switch_allocator_assert u_assert (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .xbar_sel_i  (xbar_sel_o),
        .out_ready_i (out_ready_i),
        .apb_req_i   (apb_req_i),
        .apb_rsp_i   (apb_rsp_o)
);

`default_nettype wire

// ==== verification/switch_allocator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_allocator_tb;

        import noc_alloc_pkg::*;

        localparam int          CNT_WIDTH      = 16;
        localparam int          CLK_PERIOD     = 100;
        localparam int          RESET_CYCLES   = 16;
        localparam int unsigned SEED           = 32'h8b89;
        localparam int          SINGLE_RUNS    = 20;
        localparam int          CONTEND_CYCLES = 40;
        localparam int          EN_ROUNDS      = 6;
        localparam int          EN_BURST       = 8;
        localparam int          HOLD_CYCLES    = 10;
        localparam int          APB_CYCLES     = 3;
        localparam int          APB_XFERS      = 20;
        localparam int RUN_CYCLES = RESET_CYCLES + 3 * SINGLE_RUNS + CONTEND_CYCLES +
                EN_ROUNDS * (EN_BURST + APB_CYCLES) + HOLD_CYCLES + 8 + APB_XFERS * APB_CYCLES;
        localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;

        logic                      clk = 1'b0;
        logic                      arst_n;
        port_req_t [NUM_PORTS-1:0] req;
        logic [NUM_PORTS-1:0]      out_ready;
        apb_req_t                  apb_req;
        xbar_sel_t [NUM_PORTS-1:0] xbar_sel;
        logic [NUM_PORTS-1:0]      in_ack;
        apb_rsp_t                  apb_rsp;

        // Reference model state.
        port_dir_e                 ptr_m [NUM_PORTS];
        logic [CNT_WIDTH-1:0]      cnt_m [NUM_PORTS];
        logic [NUM_PORTS-1:0]      en_m;
        logic                      clr_pend;
        xbar_sel_t [NUM_PORTS-1:0] exp_sel;
        logic [NUM_PORTS-1:0]      exp_ack;

        always #(CLK_PERIOD / 2) clk = ~clk;

        switch_allocator_top #(.CNT_WIDTH(CNT_WIDTH)) dut (
                .clk         (clk),
                .arst_n_i    (arst_n),
                .req_i       (req),
                .out_ready_i (out_ready),
                .apb_req_i   (apb_req),
                .xbar_sel_o  (xbar_sel),
                .in_ack_o    (in_ack),
                .apb_rsp_o   (apb_rsp)
        );

        task automatic abort_run();
                $display("TESTBENCH FAILED");
                $fatal(1, "simulation stopped");
        endtask

        task automatic report_mismatch(input string msg);
                $display("Error at %0t: %s", $realtime, msg);
                abort_run();
        endtask

        // Inputs that may compete for output o this cycle.
        function automatic logic [NUM_PORTS-1:0] request_mask(input int o);
                logic [NUM_PORTS-1:0] mask;
                for (int i = 0; i < NUM_PORTS; i++) begin
                        mask[i] = req[i].valid && (int'(req[i].next_hop) == o) && (i != o) &&
                                  en_m[i] && en_m[o] && out_ready[o];
                end
                return mask;
        endfunction

        // First set bit of mask in cyclic order from start; -1 if none.
        function automatic int rr_pick(input int start, input logic [NUM_PORTS-1:0] mask);
                int cand;
                for (int k = 0; k < NUM_PORTS; k++) begin
                        cand = (start + k) % NUM_PORTS;
                        if (mask[cand]) begin
                                return cand;
                        end
                end
                return -1;
        endfunction

        task automatic apb_transfer(input logic is_write, input logic [7:0] addr,
                                    input logic [31:0] wdata, output logic [31:0] rdata,
                                    output logic err);
                int waits;
                waits = 0;
                @(posedge clk);
                apb_req.psel    <= 1'b1;
                apb_req.penable <= 1'b0;
                apb_req.pwrite  <= is_write;
                apb_req.paddr   <= addr;
                apb_req.pwdata  <= wdata;
                @(posedge clk);
                apb_req.penable <= 1'b1;
                @(negedge clk);
                while (!apb_rsp.pready) begin
                        waits++;
                        if (waits > 16) begin
                                $display("APB slave never raised pready at address %h", addr);
                                abort_run();
                        end
                        @(negedge clk);
                end
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
                @(posedge clk);
                apb_req <= '0;
        endtask

        // Predicts the registered outputs of each edge.
        always @(posedge clk or negedge arst_n) begin
                int win;
                if (!arst_n) begin
                        for (int o = 0; o < NUM_PORTS; o++) begin
                                ptr_m[o] = PORT_N;
                                cnt_m[o] = '0;
                        end
                        en_m     = '1;
                        clr_pend = 1'b0;
                        exp_sel  = '0;
                        exp_ack  = '0;
                end else begin
                        exp_ack = '0;
                        for (int o = 0; o < NUM_PORTS; o++) begin
                                win = rr_pick(ptr_m[o], request_mask(o));
                                exp_sel[o].valid = (win >= 0);
                                exp_sel[o].src   = PORT_N;
                                if (win >= 0) begin
                                        exp_sel[o].src = port_dir_e'(win);
                                        exp_ack[win]   = 1'b1;
                                        ptr_m[o]       = port_dir_e'((win + 1) % NUM_PORTS);
                                        if (cnt_m[o] != '1) begin
                                                cnt_m[o] = cnt_m[o] + 1'b1;
                                        end
                                end
                        end
                        if (clr_pend) begin
                                for (int o = 0; o < NUM_PORTS; o++) begin
                                        cnt_m[o] = '0;
                                end
                        end
                        clr_pend = apb_req.psel && apb_req.penable && apb_req.pwrite &&
                                   (apb_req.paddr == REG_CNT_CLR);
                        if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
                            (apb_req.paddr == REG_PORT_EN)) begin
                                en_m = apb_req.pwdata[NUM_PORTS-1:0];
                        end
                end
        end

        always @(negedge clk) begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        assert (xbar_sel[o].valid == exp_sel[o].valid &&
                                (!exp_sel[o].valid || xbar_sel[o].src == exp_sel[o].src))
                        else report_mismatch($sformatf("output %0d select %b, model %b",
                                o, xbar_sel[o], exp_sel[o]));
                end
                assert (in_ack == exp_ack)
                else report_mismatch($sformatf("in_ack %b, model %b", in_ack, exp_ack));
                assert (dut.u_assert.err_cnt == 0)
                else report_mismatch("a bound DUT assertion fired");
        end

        initial begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
                abort_run();
        end

        initial begin
                logic [31:0] rdata;
                logic        err;
                int          src_in;
                int          hop;
                int          target;
                int          grants;
                int          saved_ptr;
                int          wins [NUM_PORTS];
                $timeformat(-9, 0, " ns", 0);
                void'($urandom(SEED));
                arst_n    = 1'b0;
                req       = '0;
                out_ready = '1;
                apb_req   = '0;
                repeat (RESET_CYCLES) @(posedge clk);
                arst_n <= 1'b1;

                apb_transfer(1'b0, REG_PORT_EN, '0, rdata, err);
                assert (!err && rdata == 32'h1f)
                else report_mismatch($sformatf("port enable reads %h after reset", rdata));

                // Lone requests that never make a U-turn.
                repeat (SINGLE_RUNS) begin
                        src_in = $urandom_range(NUM_PORTS - 1);
                        hop    = (src_in + 1 + $urandom_range(NUM_PORTS - 2)) % NUM_PORTS;
                        @(posedge clk);
                        req[src_in].valid    <= 1'b1;
                        req[src_in].next_hop <= port_dir_e'(hop);
                        @(posedge clk);
                        req <= '0;
                        @(negedge clk);
                        assert (in_ack[src_in] && xbar_sel[hop].valid &&
                                int'(xbar_sel[hop].src) == src_in)
                        else report_mismatch($sformatf("input %0d to %0d not granted",
                                src_in, hop));
                end

                // Four inputs fight for the east output.
                target = PORT_E;
                grants = 0;
                wins   = '{default: 0};
                @(posedge clk);
                for (int i = 0; i < NUM_PORTS; i++) begin
                        req[i].valid    <= (i != target);
                        req[i].next_hop <= port_dir_e'(target);
                end
                repeat (CONTEND_CYCLES) begin
                        @(negedge clk);
                        if (xbar_sel[target].valid) begin
                                wins[xbar_sel[target].src]++;
                                grants++;
                                for (int i = 0; i < NUM_PORTS; i++) begin
                                        if (i != target && grants % 4 == 0) begin
                                                assert (wins[i] == grants / 4)
                                                else report_mismatch($sformatf(
                                                        "input %0d won %0d of %0d grants",
                                                        i, wins[i], grants));
                                        end
                                end
                        end
                end
                assert (grants >= CONTEND_CYCLES - 2)
                else report_mismatch($sformatf("only %0d grants under contention", grants));

                // Random traffic with U-turns while port enables change.
                repeat (EN_ROUNDS) begin
                        apb_transfer(1'b1, REG_PORT_EN, $urandom_range(31), rdata, err);
                        assert (!err) else report_mismatch("port enable write flagged pslverr");
                        repeat (EN_BURST) begin
                                @(posedge clk);
                                for (int i = 0; i < NUM_PORTS; i++) begin
                                        req[i].valid    <= 1'($urandom_range(1));
                                        req[i].next_hop <= port_dir_e'($urandom_range(NUM_PORTS - 1));
                                end
                        end
                end
                apb_transfer(1'b1, REG_PORT_EN, 32'h1f, rdata, err);

                // West output stalls and then resumes from its old pointer.
                target = PORT_W;
                @(posedge clk);
                for (int i = 0; i < NUM_PORTS; i++) begin
                        req[i].valid    <= (i != target);
                        req[i].next_hop <= port_dir_e'(target);
                end
                repeat (4) @(posedge clk);
                out_ready[target] <= 1'b0;
                @(negedge clk);
                saved_ptr = ptr_m[target];
                repeat (HOLD_CYCLES) begin
                        @(negedge clk);
                        assert (!xbar_sel[target].valid)
                        else report_mismatch("west output granted while not ready");
                end
                @(posedge clk);
                out_ready[target] <= 1'b1;
                @(posedge clk);
                @(negedge clk);
                assert (xbar_sel[target].valid && int'(xbar_sel[target].src) ==
                        rr_pick(saved_ptr, ~(5'b00001 << target)))
                else report_mismatch("first grant after stall ignores the held pointer");

                @(posedge clk);
                req <= '0;
                for (int o = 0; o < NUM_PORTS; o++) begin
                        apb_transfer(1'b0, 8'(int'(REG_GNT_CNT_N) + 4 * o), '0, rdata, err);
                        assert (!err && rdata == cnt_m[o])
                        else report_mismatch($sformatf("counter %0d reads %0d, model %0d",
                                o, rdata, cnt_m[o]));
                end
                apb_transfer(1'b1, REG_CNT_CLR, 32'h1, rdata, err);
                for (int o = 0; o < NUM_PORTS; o++) begin
                        apb_transfer(1'b0, 8'(int'(REG_GNT_CNT_N) + 4 * o), '0, rdata, err);
                        assert (!err && rdata == 0)
                        else report_mismatch($sformatf("counter %0d reads %0d after clear",
                                o, rdata));
                end
                apb_transfer(1'b0, 8'h1c, '0, rdata, err);
                assert (err && rdata == 0)
                else report_mismatch("undefined address read without pslverr");

                repeat (2) @(negedge clk);
                if (dut.u_assert.err_cnt == 0) begin
                        $display("TESTBENCH PASSED");
                        $finish;
                end else begin
                        $display("Error at %0t: bound assertions failed", $realtime);
                        abort_run();
                end
        end

endmodule

`default_nettype wire

// ==== compile.f ====
src/noc_alloc_pkg.sv
src/route_decoder.sv
src/output_rr_arbiter.sv
src/grant_collector.sv
src/alloc_apb_regs.sv
src/switch_allocator_top.sv
verification/switch_allocator_assert.sv
verification/switch_allocator_tb.sv
